//--- include/csr_defs.svh
//////////////////////////////////////////////////////////////////////
// constants shared by the machine-mode CSR file and its counter bank
// addresses, op codes, counter slots and reset values
//////////////////////////////////////////////////////////////////////
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// widths
`define CSR_XLEN          32
`define CSR_ADDR_W        12

// machine csr addresses
`define CSR_MSTATUS       12'h300
`define CSR_MISA          12'h301
`define CSR_MTVEC         12'h305
`define CSR_MEPC          12'h341
`define CSR_MCAUSE        12'h342
`define CSR_MHARTID       12'hF14

// debug csr addresses
`define CSR_DPC           12'h7B1
`define CSR_DSCRATCH0     12'h7B2

// counter window 0x780..0x79f, plus enable and mode regs
`define CSR_PCCR_PREFIX   7'h3C
`define CSR_PCCR_ALL      12'h79F
`define CSR_PCER          12'h7A0
`define CSR_PCMR          12'h7A1

// csr operations
`define CSR_OP_NONE       2'd0
`define CSR_OP_WRITE      2'd1
`define CSR_OP_SET        2'd2
`define CSR_OP_CLEAR      2'd3

// counter slots, 2 and 3 reserved
`define PERF_N_CNT        11
`define PERF_CYCLE        0
`define PERF_INSTR        1
`define PERF_IMISS        4
`define PERF_LOAD         5
`define PERF_STORE        6
`define PERF_JUMP         7
`define PERF_BRANCH       8
`define PERF_TAKEN        9
`define PERF_COMPRESSED   10

// reset and fixed values
`define PCMR_RESET        2'd3          // enabled, saturating
`define MSTATUS_MPP_M     2'b11         // machine mode only
`define MISA_VALUE        32'h40001104  // rv32imc

`endif

//--- source/csr_pkg.sv
//////////////////////////////////////////////////////////////////////
// types for the CSR file
// one data word decoded as mstatus or as mcause
//////////////////////////////////////////////////////////////////////
`include "csr_defs.svh"

package csr_pkg;

  // csr data word, three views of the same 32 bits
  typedef union packed {
    logic [`CSR_XLEN-1:0] raw;       // plain word

    struct packed {
      logic [18:0] zero3;
      logic [1:0]  mpp;              // previous privilege, always M
      logic [2:0]  zero2;
      logic        mpie;             // previous irq enable
      logic [2:0]  zero1;
      logic        mie;              // global irq enable
      logic [2:0]  zero0;
    } mstatus;

    struct packed {
      logic        irq;              // interrupt, not exception
      logic [25:0] zero0;
      logic [4:0]  code;             // exception / irq code
    } mcause;
  } csr_word_u;

endpackage

//--- source/csr_access_unit.sv
//////////////////////////////////////////////////////////////////////
// csr port front end: read mux over identity, trap and counter regs
// and the read-modify-write data and enable for csr operations
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_access_unit
  import csr_pkg::*;
(
  // csr port
  input  logic                   csr_access_i,
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [1:0]             csr_op_i,
  input  logic [`CSR_XLEN-1:0]   csr_wdata_i,
  output logic [`CSR_XLEN-1:0]   csr_rdata_o,

  // identity
  input  logic [`CSR_XLEN-1:0]   boot_addr_i,
  input  logic [3:0]             core_id_i,
  input  logic [5:0]             cluster_id_i,

  // read data from the register units
  input  csr_word_u              trap_rdata_i,
  input  logic                   trap_hit_i,
  input  logic [`CSR_XLEN-1:0]   perf_rdata_i,
  input  logic                   perf_hit_i,

  // write side towards the register units
  output csr_word_u              csr_wdata_o,
  output logic                   csr_we_o
);

  //////////////////////////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;                               // unknown address
    case (csr_addr_i)
      `CSR_MISA: begin
        csr_rdata_o = `MISA_VALUE;
      end
      `CSR_MHARTID: begin
        // cluster at 10:5, core at 3:0
        csr_rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      end
      `CSR_MTVEC: begin
        csr_rdata_o = {boot_addr_i[`CSR_XLEN-1:8], 8'h00}; // 256 byte aligned
      end
      default: begin
        if (trap_hit_i) begin
          csr_rdata_o = trap_rdata_i.raw;
        end else if (perf_hit_i) begin
          csr_rdata_o = perf_rdata_i;
        end
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // read-modify-write
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (csr_op_i)
      `CSR_OP_WRITE: csr_wdata_o.raw = csr_wdata_i;
      `CSR_OP_SET:   csr_wdata_o.raw = csr_wdata_i | csr_rdata_o;
      `CSR_OP_CLEAR: csr_wdata_o.raw = csr_rdata_o & ~csr_wdata_i;
      default:       csr_wdata_o.raw = csr_wdata_i;  // none, not written
    endcase
  end

  // identity csrs have no storage so writes to them just vanish
  assign csr_we_o = csr_access_i && (csr_op_i != `CSR_OP_NONE);

endmodule

//--- source/csr_trap_regs.sv
//////////////////////////////////////////////////////////////////////
// trap and debug csrs: mstatus, mepc, mcause, dpc, dscratch0
// software writes plus cause save and mret / dret sequencing
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_trap_regs
  import csr_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,

  // software write
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  csr_word_u              csr_wdata_i,
  input  logic                   csr_we_i,

  // trap control
  input  logic [`CSR_XLEN-1:0]   pc_if_i,
  input  logic [`CSR_XLEN-1:0]   pc_id_i,
  input  logic                   csr_save_if_i,
  input  logic                   csr_save_id_i,
  input  logic                   csr_save_cause_i,
  input  logic [5:0]             csr_cause_i,
  input  logic                   csr_restore_mret_i,
  input  logic                   csr_restore_dret_i,

  output csr_word_u              trap_rdata_o,
  output logic                   trap_hit_o,
  output logic                   m_irq_enable_o,
  output logic [`CSR_XLEN-1:0]   mepc_o,
  output logic [`CSR_XLEN-1:0]   depc_o
);

  logic                 mie_q, mie_n;
  logic                 mpie_q, mpie_n;
  logic [5:0]           mcause_q, mcause_n;   // {irq, code}
  logic [`CSR_XLEN-1:0] mepc_q, mepc_n;
  logic [`CSR_XLEN-1:0] dpc_q, dpc_n;
  logic [`CSR_XLEN-1:0] dscratch0_q, dscratch0_n;

  // read side, also flags which addresses live here
  always_comb begin
    trap_rdata_o = '0;
    trap_hit_o   = 1'b1;
    case (csr_addr_i)
      `CSR_MSTATUS: begin
        trap_rdata_o.mstatus.mpp  = `MSTATUS_MPP_M;
        trap_rdata_o.mstatus.mpie = mpie_q;
        trap_rdata_o.mstatus.mie  = mie_q;
      end
      `CSR_MCAUSE: begin
        trap_rdata_o.mcause.irq  = mcause_q[5];
        trap_rdata_o.mcause.code = mcause_q[4:0];
      end
      `CSR_MEPC:      trap_rdata_o.raw = mepc_q;
      `CSR_DPC:       trap_rdata_o.raw = dpc_q;
      `CSR_DSCRATCH0: trap_rdata_o.raw = dscratch0_q;
      default:        trap_hit_o = 1'b0;
    endcase
  end

  // next state; trap events go last so they win over software
  always_comb begin
    mie_n       = mie_q;
    mpie_n      = mpie_q;
    mcause_n    = mcause_q;
    mepc_n      = mepc_q;
    dpc_n       = dpc_q;
    dscratch0_n = dscratch0_q;

    if (csr_we_i) begin
      case (csr_addr_i)
        `CSR_MSTATUS: begin
          mie_n  = csr_wdata_i.mstatus.mie;
          mpie_n = csr_wdata_i.mstatus.mpie;
        end
        `CSR_MCAUSE:    mcause_n    = {csr_wdata_i.mcause.irq, csr_wdata_i.mcause.code};
        `CSR_MEPC:      mepc_n      = csr_wdata_i.raw;
        `CSR_DPC:       dpc_n       = csr_wdata_i.raw;
        `CSR_DSCRATCH0: dscratch0_n = csr_wdata_i.raw;
        default: ;
      endcase
    end

    if (csr_save_cause_i) begin
      if (csr_save_if_i) begin
        mepc_n = pc_if_i;
        dpc_n  = pc_if_i;
      end else if (csr_save_id_i) begin
        mepc_n = pc_id_i;
        dpc_n  = pc_id_i;
      end
      mpie_n   = mie_q;                           // stack irq enable
      mie_n    = 1'b0;
      mcause_n = csr_cause_i;
    end else if (csr_restore_mret_i || csr_restore_dret_i) begin
      mie_n  = mpie_q;                            // unstack
      mpie_n = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q       <= 1'b0;
      mpie_q      <= 1'b0;
      mcause_q    <= '0;
      mepc_q      <= '0;
      dpc_q       <= '0;
      dscratch0_q <= '0;
    end else begin
      mie_q       <= mie_n;
      mpie_q      <= mpie_n;
      mcause_q    <= mcause_n;
      mepc_q      <= mepc_n;
      dpc_q       <= dpc_n;
      dscratch0_q <= dscratch0_n;
    end
  end

  assign m_irq_enable_o = mie_q;
  assign mepc_o         = mepc_q;
  assign depc_o         = dpc_q;

endmodule

//--- source/perf_counter_bank.sv
//////////////////////////////////////////////////////////////////////
// performance counters with event-enable (pcer) and mode (pcmr) regs
// events are registered one cycle before they bump a counter
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "csr_defs.svh"

module perf_counter_bank (
  input  logic                   clk,
  input  logic                   rst_n,

  // csr port, write data already resolved
  input  logic                   csr_access_i,
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`CSR_XLEN-1:0]   csr_wdata_i,
  input  logic                   csr_we_i,

  // events
  input  logic                   if_valid_i,
  input  logic                   id_valid_i,
  input  logic                   is_compressed_i,
  input  logic                   is_decoding_i,
  input  logic                   imiss_i,
  input  logic                   pc_set_i,
  input  logic                   jump_i,
  input  logic                   branch_i,
  input  logic                   branch_taken_i,
  input  logic                   mem_load_i,
  input  logic                   mem_store_i,

  output logic [`CSR_XLEN-1:0]   perf_rdata_o,
  output logic                   perf_hit_o
);

  logic [`PERF_N_CNT-1:0] ev_in;                  // raw event per slot
  logic [`PERF_N_CNT-1:0] inc, inc_q;             // gated, registered
  logic [`PERF_N_CNT-1:0] pcer_q;                 // event enables
  logic [1:0]             pcmr_q;                 // {saturate, enable}
  logic [`CSR_XLEN-1:0]   cnt_rd [`PERF_N_CNT];   // counter values per slot

  logic                   is_pccr, is_pcer, is_pcmr;
  logic                   pccr_all;
  logic [4:0]             pccr_idx;

  //////////////////////////////////////////////////////////////////////
  // event gating
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ev_in                   = '0;                 // reserved slots stay low
    ev_in[`PERF_CYCLE]      = 1'b1;
    ev_in[`PERF_INSTR]      = if_valid_i;
    ev_in[`PERF_IMISS]      = imiss_i & ~pc_set_i;  // fetch stall, not redirect
    ev_in[`PERF_LOAD]       = mem_load_i;
    ev_in[`PERF_STORE]      = mem_store_i;
    ev_in[`PERF_JUMP]       = jump_i;
    ev_in[`PERF_BRANCH]     = branch_i;
    ev_in[`PERF_TAKEN]      = branch_taken_i;
    ev_in[`PERF_COMPRESSED] = id_valid_i & is_decoding_i & is_compressed_i;
  end

  assign inc = ev_in & pcer_q & {`PERF_N_CNT{pcmr_q[0]}};

  //////////////////////////////////////////////////////////////////////
  // address decode and read
  //////////////////////////////////////////////////////////////////////

  assign is_pccr    = csr_access_i && (csr_addr_i[11:5] == `CSR_PCCR_PREFIX);
  assign is_pcer    = csr_access_i && (csr_addr_i == `CSR_PCER);
  assign is_pcmr    = csr_access_i && (csr_addr_i == `CSR_PCMR);
  assign pccr_all   = (csr_addr_i == `CSR_PCCR_ALL);
  assign pccr_idx   = csr_addr_i[4:0];
  assign perf_hit_o = is_pccr | is_pcer | is_pcmr;

  always_comb begin
    perf_rdata_o = '0;
    if (is_pcer) begin
      perf_rdata_o[`PERF_N_CNT-1:0] = pcer_q;
    end else if (is_pcmr) begin
      perf_rdata_o[1:0] = pcmr_q;
    end else if (is_pccr) begin
      // 0x79f and slots past the bank fall through as zero
      for (int c = 0; c < `PERF_N_CNT; c++) begin
        if (pccr_idx == c[4:0]) perf_rdata_o = cnt_rd[c];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `PERF_N_CNT; i++) begin : gen_cnt
    if (i == 2 || i == 3) begin : gen_rsvd
      assign cnt_rd[i] = '0;                      // reserved slot
    end else begin : gen_reg
      logic                 cnt_we;
      logic [`CSR_XLEN-1:0] cnt_q;

      assign cnt_we = csr_we_i && is_pccr && (pccr_all || pccr_idx == 5'(i));

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          cnt_q <= '0;
        end else if (cnt_we) begin
          cnt_q <= csr_wdata_i;                   // write beats increment
        end else if (inc_q[i] && ((cnt_q != '1) || !pcmr_q[1])) begin
          cnt_q <= cnt_q + 32'd1;                 // wraps unless saturating
        end
      end

      assign cnt_rd[i] = cnt_q;
    end
  end

  // event-enable, mode and the registered increments
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      pcmr_q <= `PCMR_RESET;
      inc_q  <= '0;
    end else begin
      if (csr_we_i && is_pcer) pcer_q <= csr_wdata_i[`PERF_N_CNT-1:0];
      if (csr_we_i && is_pcmr) pcmr_q <= csr_wdata_i[1:0];
      inc_q <= inc;
    end
  end

endmodule

//--- source/csr_file_top.sv
//////////////////////////////////////////////////////////////////////
// machine-mode CSR file top level
// access front end, trap registers and performance counter bank
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_file_top
  import csr_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,

  // csr port
  input  logic                   csr_access_i,
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [1:0]             csr_op_i,
  input  logic [`CSR_XLEN-1:0]   csr_wdata_i,
  output logic [`CSR_XLEN-1:0]   csr_rdata_o,

  // identity
  input  logic [`CSR_XLEN-1:0]   boot_addr_i,
  input  logic [3:0]             core_id_i,
  input  logic [5:0]             cluster_id_i,

  // trap control
  input  logic [`CSR_XLEN-1:0]   pc_if_i,
  input  logic [`CSR_XLEN-1:0]   pc_id_i,
  input  logic                   csr_save_if_i,
  input  logic                   csr_save_id_i,
  input  logic                   csr_save_cause_i,
  input  logic [5:0]             csr_cause_i,
  input  logic                   csr_restore_mret_i,
  input  logic                   csr_restore_dret_i,

  // counter events
  input  logic                   if_valid_i,
  input  logic                   id_valid_i,
  input  logic                   is_compressed_i,
  input  logic                   is_decoding_i,
  input  logic                   imiss_i,
  input  logic                   pc_set_i,
  input  logic                   jump_i,
  input  logic                   branch_i,
  input  logic                   branch_taken_i,
  input  logic                   mem_load_i,
  input  logic                   mem_store_i,

  output logic                   m_irq_enable_o,
  output logic [`CSR_XLEN-1:0]   mepc_o,
  output logic [`CSR_XLEN-1:0]   depc_o
);

  csr_word_u            trap_rdata;
  logic                 trap_hit;
  logic [`CSR_XLEN-1:0] perf_rdata;
  logic                 perf_hit;
  csr_word_u            csr_wdata;                // value after the op
  logic                 csr_we;

  csr_access_unit csr_access_unit_inst (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_o  (csr_rdata_o),
    .boot_addr_i  (boot_addr_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .trap_rdata_i (trap_rdata),
    .trap_hit_i   (trap_hit),
    .perf_rdata_i (perf_rdata),
    .perf_hit_i   (perf_hit),
    .csr_wdata_o  (csr_wdata),
    .csr_we_o     (csr_we)
  );

  csr_trap_regs csr_trap_regs_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .csr_addr_i         (csr_addr_i),
    .csr_wdata_i        (csr_wdata),
    .csr_we_i           (csr_we),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_cause_i        (csr_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_restore_dret_i (csr_restore_dret_i),
    .trap_rdata_o       (trap_rdata),
    .trap_hit_o         (trap_hit),
    .m_irq_enable_o     (m_irq_enable_o),
    .mepc_o             (mepc_o),
    .depc_o             (depc_o)
  );

  perf_counter_bank perf_counter_bank_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .csr_access_i    (csr_access_i),
    .csr_addr_i      (csr_addr_i),
    .csr_wdata_i     (csr_wdata.raw),             // counters take the plain word
    .csr_we_i        (csr_we),
    .if_valid_i      (if_valid_i),
    .id_valid_i      (id_valid_i),
    .is_compressed_i (is_compressed_i),
    .is_decoding_i   (is_decoding_i),
    .imiss_i         (imiss_i),
    .pc_set_i        (pc_set_i),
    .jump_i          (jump_i),
    .branch_i        (branch_i),
    .branch_taken_i  (branch_taken_i),
    .mem_load_i      (mem_load_i),
    .mem_store_i     (mem_store_i),
    .perf_rdata_o    (perf_rdata),
    .perf_hit_o      (perf_hit)
  );

endmodule

//--- testbench/csr_file_props.sv
//////////////////////////////////////////////////////////////////////
// concurrent checks on the CSR file top level
// bound into every csr_file_top instance
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_file_props (
  input logic                   clk,
  input logic                   rst_n,
  input logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input logic [`CSR_XLEN-1:0]   csr_rdata_o,
  input logic                   csr_save_if_i,
  input logic                   csr_save_id_i,
  input logic                   csr_save_cause_i,
  input logic                   csr_restore_mret_i,
  input logic                   csr_restore_dret_i,
  input logic                   m_irq_enable_o
);

  // at most one trap event per cycle
  a_trap_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({csr_save_cause_i, csr_restore_mret_i, csr_restore_dret_i}))
    else $error("save, mret and dret strobes overlap");

  a_save_src: assert property (@(posedge clk) disable iff (!rst_n)
    !(csr_save_if_i && csr_save_id_i))
    else $error("save from IF and ID at the same time");

  // a cause save always masks interrupts
  a_save_masks_irq: assert property (@(posedge clk) disable iff (!rst_n)
    csr_save_cause_i |=> !m_irq_enable_o)
    else $error("irq enable still set after cause save");

  a_mpp_machine: assert property (@(posedge clk) disable iff (!rst_n)
    (csr_addr_i == `CSR_MSTATUS) |-> (csr_rdata_o[12:11] == `MSTATUS_MPP_M))
    else $error("mstatus mpp not machine mode");

endmodule

bind csr_file_top csr_file_props csr_file_props_inst (.*);

//--- testbench/csr_file_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the machine-mode CSR file
// lfsr stimulus on the falling edge, shadow model checked every cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "csr_defs.svh"

module csr_file_tb
  import csr_pkg::*;
();

  localparam int N_RMW    = 160;
  localparam int N_ID     = 8;
  localparam int N_TRAP   = 4;
  localparam int N_CNT    = 120;
  localparam int N_FREEZE = 20;
  localparam int SCRIPT_CYCLES = 8 + N_RMW + 3*N_ID + 7*N_TRAP + N_CNT + N_FREEZE + 4 + 11 + 34;
  localparam int TIMEOUT_CYCLES = 2 * SCRIPT_CYCLES;

  logic clk, rst_n;
  logic csr_access_i;
  logic [`CSR_ADDR_W-1:0] csr_addr_i;
  logic [1:0] csr_op_i;
  logic [`CSR_XLEN-1:0] csr_wdata_i, csr_rdata_o;
  logic [`CSR_XLEN-1:0] boot_addr_i, pc_if_i, pc_id_i;
  logic [3:0] core_id_i;
  logic [5:0] cluster_id_i, csr_cause_i;
  logic csr_save_if_i, csr_save_id_i, csr_save_cause_i;
  logic csr_restore_mret_i, csr_restore_dret_i;
  logic if_valid_i, id_valid_i, is_compressed_i, is_decoding_i, imiss_i, pc_set_i;
  logic jump_i, branch_i, branch_taken_i, mem_load_i, mem_store_i;
  logic m_irq_enable_o;
  logic [`CSR_XLEN-1:0] mepc_o, depc_o;

  // shadow state
  logic m_mie, m_mpie;
  logic [5:0] m_mcause;                            // {irq, code}
  logic [31:0] m_mepc, m_dpc, m_dscr;
  logic [31:0] m_cnt [`PERF_N_CNT];
  logic [`PERF_N_CNT-1:0] m_pcer, m_lag;           // lag = events seen last edge
  logic [1:0] m_pcmr;

  logic [15:0] lfsr_q;
  int err_count;
  int cycle_cnt;

  csr_file_top csr_file_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // random source, 16 bit fibonacci lfsr
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);                  // one step per bit
      v = {v[30:0], lfsr_q[0]};
    end
    rand_bits = v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // expected read value for an address
  function automatic logic [31:0] ref_read(input logic [11:0] addr, input logic acc);
    ref_read = '0;
    if (addr == `CSR_MISA) ref_read = `MISA_VALUE;
    else if (addr == `CSR_MHARTID) ref_read = (32'(cluster_id_i) << 5) | 32'(core_id_i);
    else if (addr == `CSR_MTVEC) ref_read = boot_addr_i & 32'hFFFF_FF00;
    else if (addr == `CSR_MSTATUS) ref_read = 32'h1800 | (32'(m_mpie) << 7) | (32'(m_mie) << 3);
    else if (addr == `CSR_MCAUSE) ref_read = {m_mcause[5], 26'b0, m_mcause[4:0]};
    else if (addr == `CSR_MEPC) ref_read = m_mepc;
    else if (addr == `CSR_DPC) ref_read = m_dpc;
    else if (addr == `CSR_DSCRATCH0) ref_read = m_dscr;
    else if (acc && addr == `CSR_PCER) ref_read = {21'b0, m_pcer};
    else if (acc && addr == `CSR_PCMR) ref_read = {30'b0, m_pcmr};
    else if (acc && addr[11:5] == `CSR_PCCR_PREFIX) begin
      for (int c = 0; c < `PERF_N_CNT; c++) begin
        if (addr[4:0] == 5'(c) && c != 2 && c != 3) ref_read = m_cnt[c];
      end                                          // 0x79f and holes stay zero
    end
  endfunction

  task automatic model_reset();
    m_mie = 1'b0;
    m_mpie = 1'b0;
    m_mcause = '0;
    m_mepc = '0;
    m_dpc = '0;
    m_dscr = '0;
    m_pcer = '0;
    m_lag = '0;
    m_pcmr = 2'd3;
    for (int c = 0; c < `PERF_N_CNT; c++) m_cnt[c] = '0;
  endtask

  // one rising edge of the shadow, inputs as sampled at that edge
  task automatic model_step();
    logic [31:0] old_rd, nv;
    logic we, old_mie, old_mpie;
    logic [`PERF_N_CNT-1:0] ev;
    old_rd = ref_read(csr_addr_i, csr_access_i);
    old_mie = m_mie;
    old_mpie = m_mpie;
    we = csr_access_i && (csr_op_i != `CSR_OP_NONE);
    case (csr_op_i)
      `CSR_OP_SET:   nv = old_rd | csr_wdata_i;
      `CSR_OP_CLEAR: nv = old_rd & ~csr_wdata_i;
      default:       nv = csr_wdata_i;
    endcase
    ev = '0;
    ev[`PERF_CYCLE] = 1'b1;
    ev[`PERF_INSTR] = if_valid_i;
    ev[`PERF_IMISS] = imiss_i && !pc_set_i;
    ev[`PERF_LOAD] = mem_load_i;
    ev[`PERF_STORE] = mem_store_i;
    ev[`PERF_JUMP] = jump_i;
    ev[`PERF_BRANCH] = branch_i;
    ev[`PERF_TAKEN] = branch_taken_i;
    ev[`PERF_COMPRESSED] = id_valid_i && is_decoding_i && is_compressed_i;
    for (int i = 0; i < `PERF_N_CNT; i++) begin
      if (i == 2 || i == 3) continue;              // reserved, no storage
      if (we && csr_addr_i[11:5] == `CSR_PCCR_PREFIX &&
          (csr_addr_i == `CSR_PCCR_ALL || csr_addr_i[4:0] == 5'(i))) m_cnt[i] = nv;
      else if (m_lag[i] && !(m_pcmr[1] && m_cnt[i] == '1)) m_cnt[i] = m_cnt[i] + 32'd1;
    end
    m_lag = m_pcmr[0] ? (ev & m_pcer) : '0;        // old enables gate new events
    if (we && csr_addr_i == `CSR_PCER) m_pcer = nv[`PERF_N_CNT-1:0];
    if (we && csr_addr_i == `CSR_PCMR) m_pcmr = nv[1:0];
    if (we) begin
      case (csr_addr_i)
        `CSR_MSTATUS: begin
          m_mie = nv[3];
          m_mpie = nv[7];
        end
        `CSR_MCAUSE:    m_mcause = {nv[31], nv[4:0]};
        `CSR_MEPC:      m_mepc = nv;
        `CSR_DPC:       m_dpc = nv;
        `CSR_DSCRATCH0: m_dscr = nv;
        default: ;
      endcase
    end
    if (csr_save_cause_i) begin                    // trap beats software
      if (csr_save_if_i) begin
        m_mepc = pc_if_i;
        m_dpc = pc_if_i;
      end else if (csr_save_id_i) begin
        m_mepc = pc_id_i;
        m_dpc = pc_id_i;
      end
      m_mpie = old_mie;
      m_mie = 1'b0;
      m_mcause = csr_cause_i;
    end else if (csr_restore_mret_i || csr_restore_dret_i) begin
      m_mie = old_mpie;
      m_mpie = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare
  //////////////////////////////////////////////////////////////////////

  task automatic compare_word(input csr_word_u got, input csr_word_u exp, input string what);
    if (got.raw !== exp.raw) begin
      err_count++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got.raw, exp.raw);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_outputs();
    csr_word_u got, exp;
    got.raw = csr_rdata_o;
    exp.raw = ref_read(csr_addr_i, csr_access_i);
    compare_word(got, exp, $sformatf("read of csr %h", csr_addr_i));
    got.raw = mepc_o;
    exp.raw = m_mepc;
    compare_word(got, exp, "mepc_o");
    got.raw = depc_o;
    exp.raw = m_dpc;
    compare_word(got, exp, "depc_o");
    compare_bit(m_irq_enable_o, m_mie, "m_irq_enable_o");
  endtask

  always @(posedge clk) begin
    if (!rst_n) model_reset();
    else model_step();
    #1;                                            // let regs and read mux settle
    if (rst_n) check_outputs();
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: test still running after %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_csr(input logic [11:0] addr, input logic [1:0] op, input logic [31:0] d);
    @(negedge clk);
    csr_access_i = 1'b1;
    csr_addr_i = addr;
    csr_op_i = op;
    csr_wdata_i = d;
    csr_save_cause_i = 1'b0;                       // trap strobes last one cycle
    csr_save_if_i = 1'b0;
    csr_save_id_i = 1'b0;
    csr_restore_mret_i = 1'b0;
    csr_restore_dret_i = 1'b0;
  endtask

  task automatic random_events();
    logic [31:0] r;
    r = rand_bits(11);
    if_valid_i = r[0];
    id_valid_i = r[1];
    is_compressed_i = r[2];
    is_decoding_i = r[3];
    imiss_i = r[4];
    pc_set_i = r[5];
    jump_i = r[6];
    branch_i = r[7];
    branch_taken_i = r[8];
    mem_load_i = r[9];
    mem_store_i = r[10];
  endtask

  task automatic run_rmw_test();
    logic [31:0] r, d;
    logic [11:0] addr;
    for (int n = 0; n < N_RMW; n++) begin
      r = rand_bits(3);
      case (r % 32'd5)
        0: addr = `CSR_MSTATUS;
        1: addr = `CSR_MCAUSE;
        2: addr = `CSR_MEPC;
        3: addr = `CSR_DPC;
        default: addr = `CSR_DSCRATCH0;
      endcase
      r = rand_bits(2);
      d = rand_bits(32);
      drive_csr(addr, r[1:0], d);
      r = rand_bits(3);
      if (r[2:0] == 3'd0) csr_access_i = 1'b0;    // write without access, ignored
    end
  endtask

  task automatic run_identity_test();
    logic [31:0] r, d;
    logic [11:0] addr;
    for (int n = 0; n < N_ID; n++) begin
      for (int a = 0; a < 3; a++) begin
        addr = (a == 0) ? `CSR_MISA : (a == 1) ? `CSR_MHARTID : `CSR_MTVEC;
        r = rand_bits(2);
        d = rand_bits(32);
        drive_csr(addr, r[1:0], d);                // writes must not stick
        boot_addr_i = rand_bits(32);
        r = rand_bits(10);
        core_id_i = r[3:0];
        cluster_id_i = r[9:4];
      end
    end
  endtask

  task automatic run_trap_test();
    logic [31:0] r;
    for (int t = 0; t < N_TRAP; t++) begin
      drive_csr(`CSR_MSTATUS, `CSR_OP_SET, 32'h8);  // mie on
      drive_csr(`CSR_MEPC, `CSR_OP_WRITE, rand_bits(32));  // loses to save
      pc_if_i = rand_bits(32);
      r = rand_bits(6);
      csr_cause_i = r[5:0];
      csr_save_cause_i = 1'b1;
      csr_save_if_i = 1'b1;
      drive_csr(`CSR_MCAUSE, `CSR_OP_NONE, 32'h0);
      drive_csr(`CSR_MSTATUS, `CSR_OP_NONE, 32'h0);
      csr_restore_mret_i = 1'b1;
      drive_csr(`CSR_MSTATUS, `CSR_OP_SET, 32'h8);
      drive_csr(`CSR_DPC, `CSR_OP_WRITE, rand_bits(32));
      pc_id_i = rand_bits(32);
      r = rand_bits(6);
      csr_cause_i = r[5:0];
      csr_save_cause_i = 1'b1;
      csr_save_id_i = 1'b1;
      drive_csr(`CSR_MCAUSE, `CSR_OP_NONE, 32'h0);
      csr_restore_dret_i = 1'b1;
    end
  endtask

  task automatic run_counter_test();
    logic [31:0] r;
    drive_csr(`CSR_PCER, `CSR_OP_WRITE, 32'h61);   // cycle, load, store
    drive_csr(`CSR_PCCR_ALL, `CSR_OP_WRITE, 32'h0);
    for (int n = 0; n < N_CNT; n++) begin
      r = rand_bits(5);
      drive_csr({`CSR_PCCR_PREFIX, r[4:0]}, `CSR_OP_NONE, 32'h0);
      random_events();
    end
    drive_csr(`CSR_PCMR, `CSR_OP_CLEAR, 32'h1);    // freeze
    for (int n = 0; n < N_FREEZE; n++) begin
      r = rand_bits(5);
      drive_csr({`CSR_PCCR_PREFIX, r[4:0]}, `CSR_OP_NONE, 32'h0);
      random_events();
    end
    drive_csr(`CSR_PCMR, `CSR_OP_SET, 32'h1);
  endtask

  task automatic run_saturation_test();
    drive_csr(12'h780, `CSR_OP_WRITE, 32'hFFFF_FFFF);  // cycle counter
    repeat (4) drive_csr(12'h780, `CSR_OP_NONE, 32'h0);
    drive_csr(`CSR_PCMR, `CSR_OP_WRITE, 32'h1);    // enabled, wrapping
    drive_csr(12'h780, `CSR_OP_WRITE, 32'hFFFF_FFFF);
    repeat (4) drive_csr(12'h780, `CSR_OP_NONE, 32'h0);
    drive_csr(`CSR_PCMR, `CSR_OP_WRITE, 32'h3);
  endtask

  task automatic run_write_all_test();
    drive_csr(`CSR_PCER, `CSR_OP_WRITE, 32'hFFFF_FFFF);
    drive_csr(`CSR_PCCR_ALL, `CSR_OP_WRITE, rand_bits(32));
    for (int s = 0; s < 32; s++) begin
      drive_csr({`CSR_PCCR_PREFIX, 5'(s)}, `CSR_OP_NONE, 32'h0);  // holes read zero
    end
  endtask

  initial begin
    lfsr_q = 16'd29924;
    err_count = 0;
    cycle_cnt = 0;
    rst_n = 1'b0;
    csr_access_i = 1'b0;
    csr_addr_i = '0;
    csr_op_i = `CSR_OP_NONE;
    csr_wdata_i = '0;
    boot_addr_i = '0;
    core_id_i = '0;
    cluster_id_i = '0;
    pc_if_i = '0;
    pc_id_i = '0;
    csr_cause_i = '0;
    csr_save_if_i = 1'b0;
    csr_save_id_i = 1'b0;
    csr_save_cause_i = 1'b0;
    csr_restore_mret_i = 1'b0;
    csr_restore_dret_i = 1'b0;
    {if_valid_i, id_valid_i, is_compressed_i, is_decoding_i, imiss_i, pc_set_i} = '0;
    {jump_i, branch_i, branch_taken_i, mem_load_i, mem_store_i} = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    run_rmw_test();
    run_identity_test();
    run_trap_test();
    run_counter_test();
    run_saturation_test();
    run_write_all_test();
    repeat (2) @(negedge clk);                     // last check has run
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
source/csr_pkg.sv
source/csr_access_unit.sv
source/csr_trap_regs.sv
source/perf_counter_bank.sv
source/csr_file_top.sv
testbench/csr_file_props.sv
testbench/csr_file_tb.sv

//--- Makefile
SRCS := verilog.f $(wildcard include/*.svh source/*.sv testbench/*.sv)

obj_dir/Vcsr_file_tb: $(SRCS)
	verilator --binary --timing --assert --top-module csr_file_tb -f verilog.f

run: obj_dir/Vcsr_file_tb
	@out=$$(./obj_dir/Vcsr_file_tb); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

.PHONY: run clean
